//--- pitaya.f
hdl/pitaya_pkg.sv
hdl/adc_frontend.sv
hdl/sys_bus_decoder.sv
hdl/housekeeping_regs.sv
hdl/dac_source_regs.sv
hdl/dac_output_stage.sv
hdl/pitaya_top.sv
sim/pitaya_tb.sv

//--- sim/pitaya_tb.sv
//----------------------------------------------------------------------
// testbench for the two-channel ADC/DAC path and its register bus
// drives bus accesses and random ADC codes, checks every cycle
// against a model of the conversion and saturation rules
//----------------------------------------------------------------------

`timescale 1ns/1ps

module pitaya_tb;

  localparam int CLK_PERIOD    = 40;   // ns
  localparam int RESET_CYCLES  = 10;
  localparam int RANDOM_CYCLES = 120;  // per random run
  localparam int BUS_OPS       = 40;   // rough count, 3 cycles each
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 3 * BUS_OPS + 4 * RANDOM_CYCLES + 200;

  logic        adc_clk = 1'b0;
  logic        reset_i;
  logic [13:0] adc_dat_a_i, adc_dat_b_i, dac_a_o, dac_b_o;
  logic [31:0] sys_addr_i, sys_wdata_i, sys_rdata_o, rd;
  logic        sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;
  logic [7:0]  led_o, exp_dat_i, exp_dat_o, exp_dir_o;
  integer      seed, checks = 0, errors = 0;
  logic        acc_q = 1'b0, acc_empty_q = 1'b0;      // bus access seen at last edge
  logic [13:0] exp_dac_a, exp_dac_b, nxt_dac_a, nxt_dac_b;  // model outputs
  logic [13:0] raw_a_d1, raw_a_d2, raw_b_d1, raw_b_d2;      // captured raw codes
  logic [13:0] m_ofs_a, m_ofs_b;
  logic [1:0]  m_loop;

  pitaya_top dut (.*);

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  // raw code -> sample, add offset, clamp, back to raw code
  function automatic logic [13:0] expected_code(input logic [13:0] raw,
                                                input logic [13:0] ofs, input logic loop);
    integer smp, total;
    logic [13:0] s;
    smp   = $signed({raw[13], ~raw[12:0]});
    total = $signed(ofs) + (loop ? smp : 0);
    if (total > 8191) total = 8191;
    else if (total < -8192) total = -8192;
    s = total[13:0];
    return {s[13], ~s[12:0]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  //----------------------------------------------------------------------
  // bus tasks, reply lands in the cycle after the strobe
  //----------------------------------------------------------------------
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge adc_clk);
    #2;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;
    @(posedge adc_clk);
    #2;
    sys_wen_i = 1'b0;
    @(negedge adc_clk);  // ack checked by monitor
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge adc_clk);
    #2;
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    @(posedge adc_clk);
    #2;
    sys_ren_i = 1'b0;
    @(negedge adc_clk);
    check_value("read ack", sys_ack_o, 1);
    data = sys_rdata_o;
  endtask

  task automatic read_expect(input string what, input logic [31:0] addr,
                             input logic [31:0] exp);
    logic [31:0] data;
    bus_read(addr, data);
    check_value(what, data, exp);
  endtask

  task automatic drive_random(input int n);
    repeat (n) begin
      @(posedge adc_clk);
      #2;
      adc_dat_a_i = $random(seed);
      adc_dat_b_i = $random(seed);
    end
  endtask

  //----------------------------------------------------------------------
  // model of the ADC to DAC path and of the region 1 registers
  //----------------------------------------------------------------------
  always @(posedge adc_clk) begin
    if (reset_i) begin
      exp_dac_a = 14'h1FFF;  // code for zero
      exp_dac_b = 14'h1FFF;
      nxt_dac_a = 14'h1FFF;
      nxt_dac_b = 14'h1FFF;
      raw_a_d1  = 14'h1FFF;
      raw_a_d2  = 14'h1FFF;
      raw_b_d1  = 14'h1FFF;
      raw_b_d2  = 14'h1FFF;
      m_ofs_a   = '0;
      m_ofs_b   = '0;
      m_loop    = 2'b00;
    end else begin
      exp_dac_a = nxt_dac_a;  // dac after this edge
      exp_dac_b = nxt_dac_b;
      nxt_dac_a = expected_code(raw_a_d2, m_ofs_a, m_loop[0]);
      nxt_dac_b = expected_code(raw_b_d2, m_ofs_b, m_loop[1]);
      raw_a_d2  = raw_a_d1;
      raw_a_d1  = adc_dat_a_i;
      raw_b_d2  = raw_b_d1;
      raw_b_d1  = adc_dat_b_i;
      if (sys_wen_i && sys_addr_i[22:20] == 3'd1) begin  // writes act after this edge
        case (sys_addr_i[4:2])
          3'd0:    m_ofs_a = sys_wdata_i[13:0];
          3'd1:    m_ofs_b = sys_wdata_i[13:0];
          3'd2:    m_loop  = sys_wdata_i[1:0];
          default: ;
        endcase
      end
    end
  end

  // bus monitor, strobe of last edge
  always @(posedge adc_clk) begin
    acc_q       <= !reset_i && (sys_wen_i || sys_ren_i);
    acc_empty_q <= sys_addr_i[22:20] > 3'd1;
  end

  always @(negedge adc_clk) begin
    if (!reset_i) begin
      check_value("sys_ack_o", sys_ack_o, acc_q);
      check_value("sys_err_o", sys_err_o, acc_q && acc_empty_q);
      if (acc_q && acc_empty_q) check_value("empty region rdata", sys_rdata_o, 0);
      check_value("dac_a_o", dac_a_o, exp_dac_a);
      check_value("dac_b_o", dac_b_o, exp_dac_b);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the test sequence did not finish");
    $display("TEST FAILED");
    $finish;
  end

  //----------------------------------------------------------------------
  // test sequence
  //----------------------------------------------------------------------
  initial begin
    seed        = 32'h8b03_3b73;
    reset_i     = 1'b1;
    adc_dat_a_i = 14'h1FFF;
    adc_dat_b_i = 14'h1FFF;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    exp_dat_i   = '0;
    repeat (RESET_CYCLES) @(posedge adc_clk);
    #2 reset_i = 1'b0;
    @(negedge adc_clk);
    check_value("led_o after reset", led_o, 0);
    check_value("exp_dir_o after reset", exp_dir_o, 0);
    check_value("dac_a_o after reset", dac_a_o, 14'h1FFF);
    check_value("dac_b_o after reset", dac_b_o, 14'h1FFF);

    // housekeeping, region 0
    read_expect("ID", 32'h0000_0000, dut.ID_VALUE);
    bus_write(32'h0000_0004, 32'hFFFF_FF5A);  // upper bits dropped
    read_expect("LED readback", 32'h0000_0004, 32'h5A);
    check_value("led_o", led_o, 8'h5A);
    bus_write(32'h0000_0008, 32'h3C);
    read_expect("exp_dir readback", 32'h0000_0008, 32'h3C);
    check_value("exp_dir_o", exp_dir_o, 8'h3C);
    bus_write(32'h0000_000C, 32'hC3);
    read_expect("exp_out readback", 32'h0000_000C, 32'hC3);
    check_value("exp_dat_o", exp_dat_o, 8'hC3);
    exp_dat_i = 8'h96;
    read_expect("exp_in", 32'h0000_0010, 32'h96);
    read_expect("unmapped offset", 32'h0000_0014, 0);

    // regions 2..7 answer with an error
    for (int r = 2; r < 8; r++) begin
      bus_write(r * 32'h0010_0000 + 32'h8, 32'hDEAD_BEEF);
      bus_read(r * 32'h0010_0000 + 32'h4, rd);
    end

    // plain loopback, offsets zero
    bus_write(32'h0010_0008, 32'h3);
    read_expect("loopback readback", 32'h0010_0008, 3);
    drive_random(RANDOM_CYCLES);

    // offsets on top of the samples
    bus_write(32'h0010_0000, 32'd1000);
    bus_write(32'h0010_0004, 32'h3A24);  // -1500
    read_expect("offset B readback", 32'h0010_0004, 32'h3A24);
    drive_random(RANDOM_CYCLES);

    // clamp at both ends
    bus_write(32'h0010_0000, 32'h1F40);  // +8000
    bus_write(32'h0010_0004, 32'h20C0);  // -8000
    @(posedge adc_clk);
    #2;
    adc_dat_a_i = 14'h0000;  // +8191
    adc_dat_b_i = 14'h3FFF;  // -8192
    repeat (5) @(posedge adc_clk);
    @(negedge adc_clk);
    check_value("dac_a_o clamped high", dac_a_o, 14'h0000);
    check_value("dac_b_o clamped low", dac_b_o, 14'h3FFF);
    drive_random(RANDOM_CYCLES);

    // loopback on ch B only, then off on both
    bus_write(32'h0010_0008, 32'h2);
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    check_value("dac_a_o offset only", dac_a_o, expected_code(14'h0, 14'h1F40, 1'b0));
    bus_write(32'h0010_0008, 32'h0);
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    check_value("dac_a_o offset only", dac_a_o, expected_code(14'h0, 14'h1F40, 1'b0));
    check_value("dac_b_o offset only", dac_b_o, expected_code(14'h0, 14'h20C0, 1'b0));
    drive_random(RANDOM_CYCLES / 2);
    repeat (6) @(posedge adc_clk);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- hdl/pitaya_top.sv
//----------------------------------------------------------------------
// top level of the two-channel ADC to DAC path and its register bus
// ADC front end, bus decoder, housekeeping, DAC sources and output
// stage, all on adc_clk; ADC to DAC is four cycles
//----------------------------------------------------------------------

`timescale 1ns/1ps

module pitaya_top
  import pitaya_pkg::*;
#(
  parameter bus_data_t ID_VALUE = 32'h5250_0001  // read at region 0, offset 0
) (
  input  logic      adc_clk,
  input  logic      reset_i,
  input  adc_raw_t  adc_dat_a_i,  // ADC pins
  input  adc_raw_t  adc_dat_b_i,
  output adc_raw_t  dac_a_o,      // DAC pins, one port per channel
  output adc_raw_t  dac_b_o,
  input  bus_addr_t sys_addr_i,   // register bus
  input  bus_data_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_data_t sys_rdata_o,
  output logic      sys_ack_o,
  output logic      sys_err_o,
  output exp_t      led_o,
  input  exp_t      exp_dat_i,    // expansion connector, split in/out/dir
  output exp_t      exp_dat_o,
  output exp_t      exp_dir_o
);

  sample_t   adc_a;      // signed samples
  sample_t   adc_b;
  sum_t      sum_a;      // source sums
  sum_t      sum_b;
  logic      hk_wen;
  logic      hk_ren;
  logic      src_wen;
  logic      src_ren;
  bus_data_t hk_rdata;
  logic      hk_ack;
  logic      hk_err;
  bus_data_t src_rdata;
  logic      src_ack;
  logic      src_err;

  //----------------------------------------------------------------------
  // signal path
  //----------------------------------------------------------------------
  adc_frontend i_adc (
    .adc_clk, .reset_i, .adc_dat_a_i, .adc_dat_b_i,
    .adc_a_o (adc_a), .adc_b_o (adc_b)
  );

  dac_output_stage i_dac (
    .adc_clk, .reset_i, .sum_a_i (sum_a), .sum_b_i (sum_b),
    .dac_a_o, .dac_b_o
  );

  //----------------------------------------------------------------------
  // register bus
  //----------------------------------------------------------------------
  sys_bus_decoder i_bus (
    .adc_clk, .reset_i, .sys_addr_i, .sys_wen_i, .sys_ren_i,
    .hk_wen_o (hk_wen), .hk_ren_o (hk_ren), .src_wen_o (src_wen), .src_ren_o (src_ren),
    .hk_rdata_i (hk_rdata), .hk_ack_i (hk_ack), .hk_err_i (hk_err),
    .src_rdata_i (src_rdata), .src_ack_i (src_ack), .src_err_i (src_err),
    .sys_rdata_o, .sys_ack_o, .sys_err_o
  );

  housekeeping_regs #(.ID_VALUE (ID_VALUE)) i_hk (
    .adc_clk, .reset_i, .sys_addr_i, .sys_wdata_i,
    .sys_wen_i (hk_wen), .sys_ren_i (hk_ren),
    .sys_rdata_o (hk_rdata), .sys_ack_o (hk_ack), .sys_err_o (hk_err),
    .led_o, .exp_dat_i, .exp_dat_o, .exp_dir_o
  );

  dac_source_regs i_src (
    .adc_clk, .reset_i, .sys_addr_i, .sys_wdata_i,
    .sys_wen_i (src_wen), .sys_ren_i (src_ren),
    .sys_rdata_o (src_rdata), .sys_ack_o (src_ack), .sys_err_o (src_err),
    .adc_a_i (adc_a), .adc_b_i (adc_b), .sum_a_o (sum_a), .sum_b_o (sum_b)
  );

endmodule

//--- hdl/dac_output_stage.sv
//----------------------------------------------------------------------
// DAC output stage for both channels
// clamps each 15-bit sum into the sample range, then converts it
// to the DAC's neg-slope code; two cycles from sum to pin
//----------------------------------------------------------------------

`timescale 1ns/1ps

module dac_output_stage
  import pitaya_pkg::*;
(
  input  logic     adc_clk,
  input  logic     reset_i,   // sync, active high
  input  sum_t     sum_a_i,   // unsaturated ch A
  input  sum_t     sum_b_i,   // unsaturated ch B
  output adc_raw_t dac_a_o,   // DAC code ch A
  output adc_raw_t dac_b_o    // DAC code ch B
);

  sample_t  sat_a_q;  // saturation stage
  sample_t  sat_b_q;
  adc_raw_t dac_a_q;  // conversion stage
  adc_raw_t dac_b_q;

  // top two bits differ only on overflow
  function automatic sample_t saturate(input sum_t s);
    case (s[14:13])
      2'b01:   return SAMPLE_MAX;  // pos overflow
      2'b10:   return SAMPLE_MIN;  // neg overflow
      default: return s[13:0];
    endcase
  endfunction

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      sat_a_q <= '0;
      sat_b_q <= '0;
      dac_a_q <= 14'h1FFF;  // zero on the DAC
      dac_b_q <= 14'h1FFF;
    end else begin
      sat_a_q <= saturate(sum_a_i);         // stage 1
      sat_b_q <= saturate(sum_b_i);
      dac_a_q <= sample_to_raw(sat_a_q);    // stage 2
      dac_b_q <= sample_to_raw(sat_b_q);
    end
  end

  assign dac_a_o = dac_a_q;
  assign dac_b_o = dac_b_q;

endmodule

//--- hdl/dac_source_regs.sv
//----------------------------------------------------------------------
// DAC source registers in bus region 1
// per channel a signed offset and a loopback enable; the channel
// sum is offset plus, when looped back, the current ADC sample
//----------------------------------------------------------------------

`timescale 1ns/1ps

module dac_source_regs
  import pitaya_pkg::*;
(
  input  logic      adc_clk,
  input  logic      reset_i,      // sync, active high
  input  bus_addr_t sys_addr_i,   // offset in addr[4:2]
  input  bus_data_t sys_wdata_i,
  input  logic      sys_wen_i,    // already gated to region 1
  input  logic      sys_ren_i,
  output bus_data_t sys_rdata_o,
  output logic      sys_ack_o,
  output logic      sys_err_o,
  input  sample_t   adc_a_i,      // ADC sample ch A
  input  sample_t   adc_b_i,      // ADC sample ch B
  output sum_t      sum_a_o,      // unsaturated ch A
  output sum_t      sum_b_o       // unsaturated ch B
);

  logic [2:0] reg_ofs;
  sample_t    ofs_a_q;    // ch A offset
  sample_t    ofs_b_q;    // ch B offset
  logic [1:0] loop_q;     // bit 0 ch A, bit 1 ch B
  bus_data_t  rdata_q;
  logic       ack_q;

  assign reg_ofs = sys_addr_i[4:2];

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      ofs_a_q <= '0;
      ofs_b_q <= '0;
      loop_q  <= 2'b00;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= sys_wen_i | sys_ren_i;
      if (sys_wen_i) begin
        case (reg_ofs)
          3'd0:    ofs_a_q <= sys_wdata_i[13:0];
          3'd1:    ofs_b_q <= sys_wdata_i[13:0];
          3'd2:    loop_q  <= sys_wdata_i[1:0];
          default: ;  // holes ignore writes
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      case (reg_ofs)
        3'd0:    rdata_q <= {18'h0, ofs_a_q};  // upper bits zero
        3'd1:    rdata_q <= {18'h0, ofs_b_q};
        3'd2:    rdata_q <= {30'h0, loop_q};
        default: rdata_q <= '0;
      endcase
    end else begin
      rdata_q <= '0;
    end
  end

  //----------------------------------------------------------------------
  // channel sums, sign extended to 15 bits
  //----------------------------------------------------------------------
  assign sum_a_o = {ofs_a_q[13], ofs_a_q} +
                   (loop_q[0] ? {adc_a_i[13], adc_a_i} : 15'sd0);
  assign sum_b_o = {ofs_b_q[13], ofs_b_q} +
                   (loop_q[1] ? {adc_b_i[13], adc_b_i} : 15'sd0);

  assign sys_rdata_o = rdata_q;
  assign sys_ack_o   = ack_q;
  assign sys_err_o   = 1'b0;  // no failing offsets here

endmodule

//--- hdl/housekeeping_regs.sv
//----------------------------------------------------------------------
// housekeeping registers in bus region 0
// ID word, LEDs and the expansion connector bank; answers every
// access one cycle after the strobe, never with an error
//----------------------------------------------------------------------

`timescale 1ns/1ps

module housekeeping_regs
  import pitaya_pkg::*;
#(
  parameter bus_data_t ID_VALUE = '0  // identification word, set by top
) (
  input  logic      adc_clk,
  input  logic      reset_i,      // sync, active high
  input  bus_addr_t sys_addr_i,   // offset in addr[4:2]
  input  bus_data_t sys_wdata_i,
  input  logic      sys_wen_i,    // already gated to region 0
  input  logic      sys_ren_i,
  output bus_data_t sys_rdata_o,
  output logic      sys_ack_o,
  output logic      sys_err_o,
  output exp_t      led_o,        // board LEDs
  input  exp_t      exp_dat_i,    // expansion pins in
  output exp_t      exp_dat_o,    // expansion pins out
  output exp_t      exp_dir_o     // 1 = pin drives
);

  logic [2:0] reg_ofs;    // word offset
  exp_t       led_q;
  exp_t       exp_dir_q;
  exp_t       exp_out_q;
  exp_t       exp_in_q;   // sampled pins
  bus_data_t  rdata_q;
  logic       ack_q;

  assign reg_ofs = sys_addr_i[4:2];

  always_ff @(posedge adc_clk) begin
    exp_in_q <= exp_dat_i;  // sampled every cycle
  end

  //----------------------------------------------------------------------
  // control registers and bus reply
  //----------------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      led_q     <= '0;
      exp_dir_q <= '0;  // all pins input
      exp_out_q <= '0;
      ack_q     <= 1'b0;
    end else begin
      ack_q <= sys_wen_i | sys_ren_i;
      if (sys_wen_i) begin
        case (reg_ofs)
          3'd1:    led_q     <= sys_wdata_i[7:0];
          3'd2:    exp_dir_q <= sys_wdata_i[7:0];
          3'd3:    exp_out_q <= sys_wdata_i[7:0];
          default: ;  // ID, exp_in and holes are read only
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      case (reg_ofs)
        3'd0:    rdata_q <= ID_VALUE;
        3'd1:    rdata_q <= {24'h0, led_q};
        3'd2:    rdata_q <= {24'h0, exp_dir_q};
        3'd3:    rdata_q <= {24'h0, exp_out_q};
        3'd4:    rdata_q <= {24'h0, exp_in_q};
        default: rdata_q <= '0;  // unmapped offset
      endcase
    end else begin
      rdata_q <= '0;
    end
  end

  assign sys_rdata_o = rdata_q;
  assign sys_ack_o   = ack_q;
  assign sys_err_o   = 1'b0;     // every offset answers
  assign led_o       = led_q;
  assign exp_dat_o   = exp_out_q;
  assign exp_dir_o   = exp_dir_q;

endmodule

//--- hdl/sys_bus_decoder.sv
//----------------------------------------------------------------------
// system bus decoder, eight 1 MiB regions picked by addr[22:20]
// strobes go only to the populated regions 0 and 1; replies are
// steered by the region latched at the strobe, empty regions get err
//----------------------------------------------------------------------

`timescale 1ns/1ps

module sys_bus_decoder
  import pitaya_pkg::*;
(
  input  logic      adc_clk,      // bus runs on the sample clock
  input  logic      reset_i,      // sync, active high
  input  bus_addr_t sys_addr_i,   // master address
  input  logic      sys_wen_i,    // write strobe, one cycle
  input  logic      sys_ren_i,    // read strobe, one cycle
  output logic      hk_wen_o,     // region 0 strobes
  output logic      hk_ren_o,
  output logic      src_wen_o,    // region 1 strobes
  output logic      src_ren_o,
  input  bus_data_t hk_rdata_i,   // region 0 reply
  input  logic      hk_ack_i,
  input  logic      hk_err_i,
  input  bus_data_t src_rdata_i,  // region 1 reply
  input  logic      src_ack_i,
  input  logic      src_err_i,
  output bus_data_t sys_rdata_o,  // reply to master
  output logic      sys_ack_o,
  output logic      sys_err_o
);

  region_t region;       // region of current address
  region_t region_q;     // region of last strobe
  logic    empty_ack_q;  // strobe hit an empty region

  assign region = sys_addr_i[22:20];

  // strobe gating
  assign hk_wen_o  = sys_wen_i & (region == REGION_HK);
  assign hk_ren_o  = sys_ren_i & (region == REGION_HK);
  assign src_wen_o = sys_wen_i & (region == REGION_SRC);
  assign src_ren_o = sys_ren_i & (region == REGION_SRC);

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      region_q    <= REGION_HK;
      empty_ack_q <= 1'b0;
    end else begin
      if (sys_wen_i | sys_ren_i)
        region_q <= region;  // hold until next access
      empty_ack_q <= (sys_wen_i | sys_ren_i) &
                     (region != REGION_HK) & (region != REGION_SRC);
    end
  end

  //----------------------------------------------------------------------
  // reply mux, one cycle after the strobe
  //----------------------------------------------------------------------
  always_comb begin
    case (region_q)
      REGION_HK: begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
        sys_err_o   = hk_err_i;
      end
      REGION_SRC: begin
        sys_rdata_o = src_rdata_i;
        sys_ack_o   = src_ack_i;
        sys_err_o   = src_err_i;
      end
      default: begin               // no slave behind regions 2..7
        sys_rdata_o = '0;
        sys_ack_o   = empty_ack_q;
        sys_err_o   = empty_ack_q;
      end
    endcase
  end

endmodule

//--- hdl/adc_frontend.sv
//----------------------------------------------------------------------
// ADC capture stage for both channels
// registers the raw neg-slope codes, then registers their
// two's complement form; two cycles from pin to sample
//----------------------------------------------------------------------

`timescale 1ns/1ps

module adc_frontend
  import pitaya_pkg::*;
(
  input  logic     adc_clk,      // sample clock
  input  logic     reset_i,      // sync, active high
  input  adc_raw_t adc_dat_a_i,  // raw code ch A
  input  adc_raw_t adc_dat_b_i,  // raw code ch B
  output sample_t  adc_a_o,      // signed sample ch A
  output sample_t  adc_b_o       // signed sample ch B
);

  adc_raw_t raw_a_q;  // capture stage
  adc_raw_t raw_b_q;
  sample_t  smp_a_q;  // conversion stage
  sample_t  smp_b_q;

  //----------------------------------------------------------------------
  // capture, then convert
  //----------------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      raw_a_q <= 14'h1FFF;  // code for zero
      raw_b_q <= 14'h1FFF;
      smp_a_q <= '0;
      smp_b_q <= '0;
    end else begin
      raw_a_q <= adc_dat_a_i;                 // stage 1
      raw_b_q <= adc_dat_b_i;
      smp_a_q <= raw_to_sample(raw_a_q);      // stage 2
      smp_b_q <= raw_to_sample(raw_b_q);
    end
  end

  assign adc_a_o = smp_a_q;
  assign adc_b_o = smp_b_q;

endmodule

//--- hdl/pitaya_pkg.sv
//----------------------------------------------------------------------
// shared types, limits and code conversions for the two-channel
// ADC/DAC signal path and its register bus
// modules pull these in by a wildcard import in the module header
//----------------------------------------------------------------------

package pitaya_pkg;

  //----------------------------------------------------------------------
  // sample and bus types
  //----------------------------------------------------------------------
  typedef logic        [13:0] adc_raw_t;   // raw converter code, neg slope
  typedef logic signed [13:0] sample_t;    // two's complement sample
  typedef logic signed [14:0] sum_t;       // sum of two samples, pre saturation
  typedef logic        [31:0] bus_addr_t;  // system bus address
  typedef logic        [31:0] bus_data_t;  // system bus data word
  typedef logic        [2:0]  region_t;    // address bits 22..20
  typedef logic        [7:0]  exp_t;       // one expansion connector bank

  // sample limits
  localparam sample_t SAMPLE_MAX = 14'sh1FFF;  // +8191
  localparam sample_t SAMPLE_MIN = 14'sh2000;  // -8192

  // populated bus regions, 1 MiB each
  localparam region_t REGION_HK  = 3'd0;  // housekeeping
  localparam region_t REGION_SRC = 3'd1;  // dac source registers

  //----------------------------------------------------------------------
  // code conversions
  //----------------------------------------------------------------------
  // keep msb, invert the other 13 bits; the rule is its own inverse
  function automatic sample_t raw_to_sample(input adc_raw_t raw);
    return {raw[13], ~raw[12:0]};
  endfunction

  function automatic adc_raw_t sample_to_raw(input sample_t smp);
    return {smp[13], ~smp[12:0]};
  endfunction

endpackage
